/* rtl/ffp_cfg_pkg.sv */
/* Datapath widths, pulser latency and the register write word
   Imported by the register bank, the pulse engine and the top level */
package ffp_cfg_pkg;

   localparam int DWI       = 18;  // Setpoint and output width, signed
   localparam int SLEW_WI   = 17;  // Max output change per cycle
   localparam int LENGTH_WI = 32;  // Pulse length counter
   localparam int PIPE_LAT  = 3;   // Start marker to ramp datapath
   localparam int WDATA_WI  = 36;  // Register write data

   // Setpoint view with x in the upper half
   typedef struct packed {
      logic signed [DWI-1:0] x;
      logic signed [DWI-1:0] y;
   } setp_pair_t;

   // Scalar view
   typedef struct packed {
      logic [WDATA_WI-LENGTH_WI-1:0] pad;    // Unused top bits
      logic [LENGTH_WI-1:0]          value;  // Length, slew, delay or control
   } scalar_t;

   // One write word, decoded by address
   typedef union packed {
      setp_pair_t setp;
      scalar_t    scalar;
   } cfg_word_u;

endpackage

/* rtl/ffp_regs_pkg.sv */
/* Register map of the pulse generator
   Addresses and control bit positions shared by the register bank and testbench */
package ffp_regs_pkg;

   localparam int ADDR_WI = 3;

   localparam logic [ADDR_WI-1:0] REG_LENGTH     = ADDR_WI'(0);  // Total pulse length
   localparam logic [ADDR_WI-1:0] REG_SLEW       = ADDR_WI'(1);  // Slew limit
   localparam logic [ADDR_WI-1:0] REG_SETP       = ADDR_WI'(2);  // x and y setpoints
   localparam logic [ADDR_WI-1:0] REG_TRIG_DELAY = ADDR_WI'(3);
   localparam logic [ADDR_WI-1:0] REG_TRIG_CTRL  = ADDR_WI'(4);
   localparam logic [ADDR_WI-1:0] REG_STATUS     = ADDR_WI'(5);  // Read only, bit 0 busy

   // TRIG_CTRL bits
   localparam int EN_EXT_BIT   = 0;  // Allow external trigger
   localparam int SW_START_BIT = 1;  // Software start, self-clearing

endpackage

/* rtl/reg_delay.sv */
/* Fixed-length delay line with asynchronous clear
   Delays a dw-bit word by len clock cycles */
`timescale 1ns/1ps

module reg_delay #(
   parameter int dw  = 1,
   parameter int len = 1
) (
   input  logic          clk,
   input  logic          arst_n,
   input  logic [dw-1:0] din,
   output logic [dw-1:0] dout
);
   logic [dw-1:0] sr [len];  // Stage 0 takes din

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < len; i++) begin
            sr[i] <= '0;
         end
      end else begin
         sr[0] <= din;
         for (int i = 1; i < len; i++) begin
            sr[i] <= sr[i-1];  // Shift one stage
         end
      end
   end

   assign dout = sr[len-1];

endmodule

/* rtl/ff_pulser.sv */
/* Two-channel feedforward pulse engine
   Ramps both setpoints up at the slew limit, holds them and ramps them back to zero
   so the pulse ends at the programmed length; start is ignored while pulsing */
`timescale 1ns/1ps

module ff_pulser #(
   parameter int PIPE_LAT = ffp_cfg_pkg::PIPE_LAT
) (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               start,
   input  logic [ffp_cfg_pkg::LENGTH_WI-1:0]  length,    // Rise, flat top and fall
   input  logic [ffp_cfg_pkg::SLEW_WI-1:0]    slew_lim,  // Must be nonzero
   input  logic signed [ffp_cfg_pkg::DWI-1:0] setp_x,
   input  logic signed [ffp_cfg_pkg::DWI-1:0] setp_y,
   output logic                               busy,
   output logic signed [ffp_cfg_pkg::DWI-1:0] out_x,
   output logic signed [ffp_cfg_pkg::DWI-1:0] out_y
);
   import ffp_cfg_pkg::*;

   localparam int MWI = DWI - 1;  // Magnitude width
   localparam int AWI = DWI + 1;  // Ramp headroom for overshoot before railing

   logic                  pulse_on;
   logic                  pulse_on_dly;  // pulse_on aligned with the ramp
   logic                  fall;          // Ramp down phase
   logic [LENGTH_WI-1:0]  len_cnt;
   logic [LENGTH_WI-1:0]  rise_cnt;      // Cycles until both channels rail
   logic [LENGTH_WI-1:0]  fall_t;        // len_cnt value that starts the fall
   logic signed [DWI-1:0] setp [2];      // Channel 0 is x, 1 is y
   logic [MWI-1:0]        mag [2];       // Setpoint magnitudes
   logic [AWI-1:0]        nxt [2];       // Unclamped ramp
   logic [MWI-1:0]        us [2];        // Clamped magnitude
   logic signed [DWI-1:0] out_r [2];
   logic [1:0]            railed;
   logic [1:0]            railed_r;      // Matches length counter timing

   // Magnitude with -full scale saturated
   function automatic logic [MWI-1:0] abs_sat(input logic signed [DWI-1:0] v);
      logic [DWI-1:0] m;
      m = v[DWI-1] ? -v : v;
      return m[DWI-1] ? {MWI{1'b1}} : m[MWI-1:0];
   endfunction

   assign setp[0] = setp_x;
   assign setp[1] = setp_y;

   reg_delay #(
      .dw  (1),
      .len (PIPE_LAT)
   ) pipe_lat_i (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (pulse_on),
      .dout   (pulse_on_dly)
   );

   // Length and phase control
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pulse_on <= 1'b0;
         fall     <= 1'b0;
         len_cnt  <= '0;
         rise_cnt <= '0;
         fall_t   <= '0;
      end else if (start && !pulse_on && !pulse_on_dly) begin  // Pipeline must be drained
         pulse_on <= 1'b1;
         fall     <= 1'b0;
         len_cnt  <= '0;
         rise_cnt <= '0;
         fall_t   <= '0;
      end else if (pulse_on && pulse_on_dly) begin
         len_cnt <= len_cnt + 1'b1;
         if (len_cnt == length) begin
            pulse_on <= 1'b0;  // Hard stop at length
         end
         if (fall_t != '0 && len_cnt == fall_t) begin
            fall <= 1'b1;
         end
         if (railed_r == 2'b11) begin
            // Fall mirrors the rise plus pipeline slack
            fall_t <= length - rise_cnt - LENGTH_WI'(5);
         end else if (!fall) begin
            rise_cnt <= rise_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int c = 0; c < 2; c++) begin
         mag[c] <= abs_sat(setp[c]);
      end
   end

   // Ramp step
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int c = 0; c < 2; c++) begin
            nxt[c] <= '0;
         end
      end else begin
         for (int c = 0; c < 2; c++) begin
            if (!pulse_on) begin
               nxt[c] <= '0;
            end else if (railed[c]) begin
               nxt[c] <= AWI'(mag[c]);                   // Hold at the rail
            end else if (!fall) begin
               nxt[c] <= nxt[c] + AWI'(slew_lim);
            end else if (nxt[c] > AWI'(slew_lim)) begin
               nxt[c] <= nxt[c] - AWI'(slew_lim);
            end else begin
               nxt[c] <= '0;                             // Clamp at zero
            end
         end
      end
   end

   // Rail detect and clamp
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         railed   <= '0;
         railed_r <= '0;
         for (int c = 0; c < 2; c++) begin
            us[c] <= '0;
         end
      end else if (!pulse_on) begin
         railed   <= '0;
         railed_r <= '0;
         for (int c = 0; c < 2; c++) begin
            us[c] <= '0;
         end
      end else begin
         railed_r <= railed;
         for (int c = 0; c < 2; c++) begin
            if (fall) begin
               railed[c] <= 1'b0;
               us[c]     <= nxt[c][MWI-1:0];      // Never above mag here
            end else if (nxt[c] >= AWI'(mag[c])) begin
               railed[c] <= 1'b1;
               us[c]     <= mag[c];
            end else begin
               us[c] <= nxt[c][MWI-1:0];
            end
         end
      end
   end

   // Sign restore
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int c = 0; c < 2; c++) begin
            out_r[c] <= '0;
         end
      end else begin
         for (int c = 0; c < 2; c++) begin
            out_r[c] <= setp[c][DWI-1] ? -DWI'(us[c]) : DWI'(us[c]);
         end
      end
   end

   assign out_x = out_r[0];
   assign out_y = out_r[1];
   assign busy  = pulse_on;

endmodule

/* rtl/ffp_regbank.sv */
/* Settings registers of the pulse generator
   Decodes plain address/strobe writes and returns any register on a registered read */
`timescale 1ns/1ps

module ffp_regbank #(
   parameter int TRIG_DELAY_WI = 16
) (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               wr_en,
   input  logic [ffp_regs_pkg::ADDR_WI-1:0]   wr_addr,
   input  logic [ffp_cfg_pkg::WDATA_WI-1:0]   wr_data,
   input  logic [ffp_regs_pkg::ADDR_WI-1:0]   rd_addr,
   input  logic                               busy,
   output logic [ffp_cfg_pkg::WDATA_WI-1:0]   rd_data,
   output logic [ffp_cfg_pkg::LENGTH_WI-1:0]  length,
   output logic [ffp_cfg_pkg::SLEW_WI-1:0]    slew_lim,
   output logic signed [ffp_cfg_pkg::DWI-1:0] setp_x,
   output logic signed [ffp_cfg_pkg::DWI-1:0] setp_y,
   output logic [TRIG_DELAY_WI-1:0]           trig_delay,
   output logic                               ext_en,
   output logic                               sw_start
);
   import ffp_cfg_pkg::*;
   import ffp_regs_pkg::*;

   cfg_word_u wr_word;  // Write data seen through either view
   cfg_word_u rd_word;  // Readback before the output register

   assign wr_word = wr_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         length     <= '0;
         slew_lim   <= '0;
         setp_x     <= '0;
         setp_y     <= '0;
         trig_delay <= '0;
         ext_en     <= 1'b0;
         sw_start   <= 1'b0;
      end else begin
         sw_start <= 1'b0;  // One cycle only
         if (wr_en) begin
            case (wr_addr)
               REG_LENGTH:     length     <= wr_word.scalar.value;
               REG_SLEW:       slew_lim   <= wr_word.scalar.value[SLEW_WI-1:0];
               REG_TRIG_DELAY: trig_delay <= wr_word.scalar.value[TRIG_DELAY_WI-1:0];
               REG_SETP: begin
                  setp_x <= wr_word.setp.x;  // Upper half
                  setp_y <= wr_word.setp.y;
               end
               REG_TRIG_CTRL: begin
                  ext_en   <= wr_word.scalar.value[EN_EXT_BIT];
                  sw_start <= wr_word.scalar.value[SW_START_BIT];
               end
               default: ;  // Status and unmapped ignore writes
            endcase
         end
      end
   end

   // Readback mux
   always_comb begin
      rd_word = '0;
      case (rd_addr)
         REG_LENGTH:     rd_word.scalar.value                      = length;
         REG_SLEW:       rd_word.scalar.value[SLEW_WI-1:0]         = slew_lim;
         REG_TRIG_DELAY: rd_word.scalar.value[TRIG_DELAY_WI-1:0]   = trig_delay;
         REG_TRIG_CTRL:  rd_word.scalar.value[EN_EXT_BIT]          = ext_en;  // Start reads 0
         REG_STATUS:     rd_word.scalar.value[0]                   = busy;
         REG_SETP: begin
            rd_word.setp.x = setp_x;
            rd_word.setp.y = setp_y;
         end
         default:        rd_word = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      rd_data <= rd_word;  // Valid one cycle after rd_addr
   end

endmodule

/* rtl/ffp_trigger.sv */
/* Pulse trigger with programmable start delay
   Merges the software strobe with the external trigger edge and drops triggers while busy */
`timescale 1ns/1ps

module ffp_trigger #(
   parameter int TRIG_DELAY_WI = 16
) (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     ext_trig,  // Synchronous to clk
   input  logic                     ext_en,
   input  logic                     sw_start,
   input  logic                     busy,
   input  logic [TRIG_DELAY_WI-1:0] trig_delay,
   output logic                     start
);
   logic                     ext_trig_d;  // Last ext_trig level
   logic                     ext_rise;
   logic                     trig_ok;     // Trigger accepted
   logic                     pending;     // Delay count running
   logic [TRIG_DELAY_WI-1:0] cnt;
   logic                     fire;

   assign ext_rise = ext_en && ext_trig && !ext_trig_d;
   assign trig_ok  = (sw_start || ext_rise) && !busy && !pending && !start;

   // Zero delay fires at once, otherwise on the last count
   assign fire = (trig_ok && trig_delay == '0) ||
                 (pending && cnt == TRIG_DELAY_WI'(1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ext_trig_d <= 1'b1;  // Level high out of reset is no edge
         pending    <= 1'b0;
         cnt        <= '0;
         start      <= 1'b0;
      end else begin
         ext_trig_d <= ext_trig;
         start      <= fire;
         if (trig_ok && trig_delay != '0) begin
            pending <= 1'b1;
            cnt     <= trig_delay;
         end else if (pending) begin
            cnt <= cnt - 1'b1;
            if (fire) begin
               pending <= 1'b0;
            end
         end
      end
   end

endmodule

/* rtl/ffp_top.sv */
/* Feedforward pulse generator top level
   Register bank, trigger and pulse engine behind a plain write/read register port */
`timescale 1ns/1ps

module ffp_top #(
   parameter int TRIG_DELAY_WI = 16
) (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               wr_en,
   input  logic [ffp_regs_pkg::ADDR_WI-1:0]   wr_addr,
   input  logic [ffp_cfg_pkg::WDATA_WI-1:0]   wr_data,
   input  logic [ffp_regs_pkg::ADDR_WI-1:0]   rd_addr,
   output logic [ffp_cfg_pkg::WDATA_WI-1:0]   rd_data,
   input  logic                               ext_trig,
   output logic signed [ffp_cfg_pkg::DWI-1:0] out_x,
   output logic signed [ffp_cfg_pkg::DWI-1:0] out_y,
   output logic                               busy
);
   import ffp_cfg_pkg::*;

   logic [LENGTH_WI-1:0]     length;
   logic [SLEW_WI-1:0]       slew_lim;
   logic signed [DWI-1:0]    setp_x;
   logic signed [DWI-1:0]    setp_y;
   logic [TRIG_DELAY_WI-1:0] trig_delay;
   logic                     ext_en;
   logic                     sw_start;  // From TRIG_CTRL write
   logic                     start;     // Delayed trigger into the pulser

   ffp_regbank #(.TRIG_DELAY_WI(TRIG_DELAY_WI)) regbank_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .rd_addr    (rd_addr),
      .busy       (busy),
      .rd_data    (rd_data),
      .length     (length),
      .slew_lim   (slew_lim),
      .setp_x     (setp_x),
      .setp_y     (setp_y),
      .trig_delay (trig_delay),
      .ext_en     (ext_en),
      .sw_start   (sw_start)
   );

   ffp_trigger #(.TRIG_DELAY_WI(TRIG_DELAY_WI)) trigger_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .ext_trig   (ext_trig),
      .ext_en     (ext_en),
      .sw_start   (sw_start),
      .busy       (busy),
      .trig_delay (trig_delay),
      .start      (start)
   );

   ff_pulser #(.PIPE_LAT(PIPE_LAT)) pulser_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .start    (start),
      .length   (length),
      .slew_lim (slew_lim),
      .setp_x   (setp_x),
      .setp_y   (setp_y),
      .busy     (busy),
      .out_x    (out_x),
      .out_y    (out_y)
   );

endmodule

/* bench/ffp_chk.sv */
/* Assertions bound into the pulse engine
   Checks busy width, output slew and zero outputs while idle */
`timescale 1ns/1ps

module ffp_chk #(
   parameter int PIPE_LAT = ffp_cfg_pkg::PIPE_LAT
) (
   input logic                               clk,
   input logic                               arst_n,
   input logic                               busy,
   input logic [ffp_cfg_pkg::SLEW_WI-1:0]    slew_lim,
   input logic signed [ffp_cfg_pkg::DWI-1:0] out_x,
   input logic signed [ffp_cfg_pkg::DWI-1:0] out_y
);
   import ffp_cfg_pkg::*;

   int fail_cnt = 0;  // Failed assertions so far

   // Absolute difference of two output samples
   function automatic int step_size(input logic signed [DWI-1:0] a,
                                    input logic signed [DWI-1:0] b);
      int d;
      d = int'(a) - int'(b);
      return (d < 0) ? -d : d;
   endfunction

   busy_min_width: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(busy) |-> $past(busy, PIPE_LAT))
   else begin
      $error("busy fell after fewer than %0d cycles high", PIPE_LAT);
      fail_cnt++;
   end

   slew_x: assert property (@(posedge clk) disable iff (!arst_n)
      step_size(out_x, $past(out_x)) <= int'(slew_lim))
   else begin
      $error("out_x step exceeds the slew limit");
      fail_cnt++;
   end

   slew_y: assert property (@(posedge clk) disable iff (!arst_n)
      step_size(out_y, $past(out_y)) <= int'(slew_lim))
   else begin
      $error("out_y step exceeds the slew limit");
      fail_cnt++;
   end

   // Pipeline drained after PIPE_LAT+1 idle cycles
   idle_zero: assert property (@(posedge clk) disable iff (!arst_n)
      !busy [*PIPE_LAT+1] |-> (out_x == '0 && out_y == '0))
   else begin
      $error("outputs nonzero while the pulser is idle");
      fail_cnt++;
   end

endmodule

bind ff_pulser ffp_chk #(.PIPE_LAT(PIPE_LAT)) chk_i (
   .clk      (clk),
   .arst_n   (arst_n),
   .busy     (busy),
   .slew_lim (slew_lim),
   .out_x    (out_x),
   .out_y    (out_y)
);

/* bench/ffp_tb.sv */
/* Testbench for the feedforward pulse generator
   Each pattern line sets the registers, reads them back, triggers one pulse and checks
   busy timing and both outputs every cycle */
`timescale 1ns/1ps

module ffp_tb;
   import ffp_cfg_pkg::*;
   import ffp_regs_pkg::*;

   localparam int NUM_TESTS = 8;
   localparam int NUM_COLS  = 7;   // Words per pattern line
   localparam int TDW       = 16;  // Trigger delay counter width

   logic                  clk;
   logic                  arst_n;
   logic                  wr_en;
   logic [ADDR_WI-1:0]    wr_addr;
   logic [WDATA_WI-1:0]   wr_data;
   logic [ADDR_WI-1:0]    rd_addr;
   logic [WDATA_WI-1:0]   rd_data;
   logic                  ext_trig;
   logic signed [DWI-1:0] out_x;
   logic signed [DWI-1:0] out_y;
   logic                  busy;

   logic [31:0]           pat [NUM_TESTS*NUM_COLS];
   longint                budget;      // Watchdog limit in cycles
   logic [31:0]           t_len;
   logic [31:0]           t_slew;
   logic [31:0]           t_delay;
   logic [31:0]           t_src;       // 0 software, 1 external
   logic [31:0]           t_busy_exp;
   logic signed [DWI-1:0] sx;
   logic signed [DWI-1:0] sy;
   int                    mag_x;
   int                    mag_y;
   int                    peak_x;
   int                    peak_y;
   int                    prev_x;      // Last sampled outputs
   int                    prev_y;

   ffp_top #(.TRIG_DELAY_WI(TDW)) ffp_top_i (
      .clk      (clk),
      .arst_n   (arst_n),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .ext_trig (ext_trig),
      .out_x    (out_x),
      .out_y    (out_y),
      .busy     (busy)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;  // 8 ns period

   function automatic int abs_int(input int v);
      return (v < 0) ? -v : v;
   endfunction

   function automatic int ceil_div(input int a, input int b);
      return (a + b - 1) / b;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "Run stopped at first error");
   endtask

   // Inputs change 1 ns after the edge when outputs have settled
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic watchdog();
      repeat (budget) @(posedge clk);
      abort_run("Timeout: a pulse never finished within the cycle budget");
   endtask

   task automatic write_reg(input logic [ADDR_WI-1:0] addr, input logic [WDATA_WI-1:0] data);
      wr_en   = 1'b1;
      wr_addr = addr;
      wr_data = data;
      tick();               // Takes effect on this edge
      wr_en   = 1'b0;
   endtask

   task automatic check_read(input logic [ADDR_WI-1:0] addr, input logic [WDATA_WI-1:0] exp);
      rd_addr = addr;
      tick();               // rd_data one cycle later
      assert (rd_data === exp) else
         abort_run($sformatf("Mismatch at %0t: register %0d read %h, expected %h",
                             $time, addr, rd_data, exp));
   endtask

   // Sign, magnitude and slew of both outputs
   task automatic check_sample();
      int vx;
      int vy;
      vx = int'(out_x);
      vy = int'(out_y);
      assert (abs_int(vx) <= mag_x && abs_int(vy) <= mag_y) else
         abort_run($sformatf("Mismatch at %0t: outputs %0d/%0d above setpoint magnitude %0d/%0d",
                             $time, vx, vy, mag_x, mag_y));
      assert ((vx == 0 || out_x[DWI-1] == sx[DWI-1]) &&
              (vy == 0 || out_y[DWI-1] == sy[DWI-1])) else
         abort_run($sformatf("Mismatch at %0t: output sign differs from setpoint, %0d/%0d",
                             $time, vx, vy));
      assert (abs_int(vx - prev_x) <= int'(t_slew) && abs_int(vy - prev_y) <= int'(t_slew)) else
         abort_run($sformatf("Mismatch at %0t: output step above slew limit %0d",
                             $time, t_slew));
      if (abs_int(vx) > peak_x) peak_x = abs_int(vx);
      if (abs_int(vy) > peak_y) peak_y = abs_int(vy);
      prev_x = vx;
      prev_y = vy;
   endtask

   // Counts from the edge that saw the trigger
   task automatic run_pulse(input int rise_exp, input bit retrig);
      int k;
      int hi;
      k  = 0;
      hi = 0;
      while (!busy) begin
         check_sample();
         tick();
         k++;
      end
      assert (k == rise_exp) else
         abort_run($sformatf("Mismatch at %0t: busy rose %0d cycles after trigger, expected %0d",
                             $time, k, rise_exp));
      while (busy) begin
         check_sample();
         if (retrig && hi == int'(t_busy_exp) - 2) ext_trig = 1'b0;
         if (retrig && hi == int'(t_busy_exp) - 1) ext_trig = 1'b1;  // Edge in last busy cycle
         tick();
         hi++;
      end
      assert (hi == int'(t_busy_exp)) else
         abort_run($sformatf("Mismatch at %0t: busy high %0d cycles, expected %0d",
                             $time, hi, t_busy_exp));
      repeat (PIPE_LAT + 1) begin
         check_sample();
         tick();
      end
      assert (out_x == '0 && out_y == '0) else
         abort_run($sformatf("Mismatch at %0t: outputs %0d/%0d not zero after drain",
                             $time, out_x, out_y));
      ext_trig = 1'b0;
      repeat (int'(t_delay) + 4) begin
         tick();
         assert (!busy) else abort_run("An extra pulse started after busy fell");
      end
   endtask

   initial begin
      int nx;
      int ny;
      int n_max;
      arst_n   = 1'b0;
      wr_en    = 1'b0;
      wr_addr  = '0;
      wr_data  = '0;
      rd_addr  = '0;
      ext_trig = 1'b0;
      $readmemh("bench/ffp_patterns.txt", pat);
      budget = 40;  // Reset and idle readback
      for (int t = 0; t < NUM_TESTS; t++) begin
         budget += 3 * pat[t*NUM_COLS+4] + pat[t*NUM_COLS] + 50;  // Up to three delay waits
      end
      fork
         watchdog();
      join_none
      repeat (8) @(posedge clk);
      #1;
      arst_n = 1'b1;
      tick();
      for (int a = 0; a < 6; a++) begin
         check_read(ADDR_WI'(a), '0);  // Everything clear after reset
      end

      for (int t = 0; t < NUM_TESTS; t++) begin
         t_len      = pat[t*NUM_COLS+0];
         t_slew     = pat[t*NUM_COLS+1];
         sx         = pat[t*NUM_COLS+2][DWI-1:0];
         sy         = pat[t*NUM_COLS+3][DWI-1:0];
         t_delay    = pat[t*NUM_COLS+4];
         t_src      = pat[t*NUM_COLS+5];
         t_busy_exp = pat[t*NUM_COLS+6];
         mag_x      = abs_int(int'(sx));
         mag_y      = abs_int(int'(sy));
         peak_x     = 0;
         peak_y     = 0;
         prev_x     = 0;
         prev_y     = 0;

         write_reg(REG_LENGTH, WDATA_WI'(t_len));
         write_reg(REG_SLEW, WDATA_WI'(t_slew));
         write_reg(REG_SETP, {sx, sy});                 // x in the upper half
         write_reg(REG_TRIG_DELAY, WDATA_WI'(t_delay));
         write_reg(REG_TRIG_CTRL, '0);
         check_read(REG_LENGTH, WDATA_WI'(t_len));
         check_read(REG_SLEW, WDATA_WI'(t_slew));
         check_read(REG_SETP, {sx, sy});
         check_read(REG_TRIG_DELAY, WDATA_WI'(t_delay));
         check_read(REG_TRIG_CTRL, '0);
         check_read(REG_STATUS, '0);                    // Idle

         if (t_src == 0) begin
            write_reg(REG_TRIG_CTRL, WDATA_WI'(1) << SW_START_BIT);
            run_pulse(int'(t_delay) + 2, 1'b0);
         end else begin
            ext_trig = 1'b1;                            // ext_en still clear
            repeat (int'(t_delay) + 4) begin
               tick();
               assert (!busy) else abort_run("External trigger started a pulse with ext_en clear");
            end
            ext_trig = 1'b0;
            write_reg(REG_TRIG_CTRL, WDATA_WI'(1) << EN_EXT_BIT);
            check_read(REG_TRIG_CTRL, WDATA_WI'(1) << EN_EXT_BIT);
            ext_trig = 1'b1;
            tick();                                     // Edge seen here
            run_pulse(int'(t_delay) + 1, 1'b1);
         end

         // Full ramps fit when length covers rise, fall and overhead
         nx    = ceil_div(mag_x, int'(t_slew));
         ny    = ceil_div(mag_y, int'(t_slew));
         n_max = (nx > ny) ? nx : ny;
         if (int'(t_len) >= 2 * n_max + 4) begin
            assert (peak_x == mag_x && peak_y == mag_y) else
               abort_run($sformatf("Mismatch at %0t: peaks %0d/%0d, expected %0d/%0d",
                                   $time, peak_x, peak_y, mag_x, mag_y));
         end
      end

      if (ffp_top_i.pulser_i.chk_i.fail_cnt == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         abort_run($sformatf("%0d bound assertion failures in the pulse engine",
                             ffp_top_i.pulser_i.chk_i.fail_cnt));
      end
   end

endmodule

/* bench/ffp_patterns.txt */
// length slew_lim setp_x setp_y trig_delay source expected_busy, all hex
// source 0 is a software start, 1 is an external trigger edge; setpoints are 18-bit two's complement
00000040 00001000 08000 04000 0000 0 00000044
00000030 00000800 3b1e0 07530 0005 0 00000034
00000020 00002000 10000 3fc18 000a 1 00000024
00000064 000000ff 01000 3f000 0003 0 00000068
00000010 0001ffff 1ffff 20001 0000 1 00000014
0000000c 00004000 0c000 00000 0001 0 00000010
000000c8 00000100 3b000 02800 0014 1 000000cc
00000018 00000400 00200 3fe00 0002 0 0000001c

/* verilog.f */
rtl/ffp_cfg_pkg.sv
rtl/ffp_regs_pkg.sv
rtl/reg_delay.sv
rtl/ff_pulser.sv
rtl/ffp_regbank.sv
rtl/ffp_trigger.sv
rtl/ffp_top.sv
bench/ffp_chk.sv
bench/ffp_tb.sv

/* Bender.yml */
package:
  name: ffp_pulser

sources:
  - files:
      - rtl/ffp_cfg_pkg.sv
      - rtl/ffp_regs_pkg.sv
      - rtl/reg_delay.sv
      - rtl/ff_pulser.sv
      - rtl/ffp_regbank.sv
      - rtl/ffp_trigger.sv
      - rtl/ffp_top.sv
  - target: simulation
    files:
      - bench/ffp_chk.sv
      - bench/ffp_tb.sv
